//--- common/vlsu_config.svh
`ifndef VLSU_CONFIG_SVH
`define VLSU_CONFIG_SVH

// Vector register geometry
`define VLSU_VLEN       64
`define VLSU_VLENB      8

// Memory word
`define VLSU_WORD_W     32

// Major opcodes of vector loads and stores
`define VLSU_OPC_LOAD   7'b0000111
`define VLSU_OPC_STORE  7'b0100111

// Instruction field positions
`define VLSU_OPC_MSB    6
`define VLSU_OPC_LSB    0
`define VLSU_WIDTH_MSB  14
`define VLSU_WIDTH_LSB  12
`define VLSU_MOP_MSB    27
`define VLSU_MOP_LSB    26

`endif

//--- common/vlsu_ctrl_pkg.sv
`include "vlsu_config.svh"

package vlsu_ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        VLSU_IDLE   = 2'd0,
        VLSU_ACCESS = 2'd1,
        VLSU_DRAIN  = 2'd2
    } vlsu_state_e;

    // Element index or count, 0 to VLENB inclusive
    typedef logic [$clog2(`VLSU_VLENB + 1)-1:0] elem_idx_t;

endpackage

//--- common/vlsu_isa_pkg.sv
package vlsu_isa_pkg;

    // Element width, doubles as a shift amount for byte counts
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } vew_e;

    // Addressing mode, same encoding as the mop field
    typedef enum logic [1:0] {
        UNIT_STRIDED      = 2'b00,
        INDEXED_UNORDERED = 2'b01,
        STRIDED           = 2'b10,
        INDEXED_ORDERED   = 2'b11
    } addr_mode_e;

    // Transfer direction
    typedef enum logic {
        VOP_LOAD  = 1'b0,
        VOP_STORE = 1'b1
    } vop_e;

endpackage

//--- tests/tb_vlsu.sv
`timescale 1ns/1ps
`include "vlsu_config.svh"

module tb_vlsu;
    import vlsu_isa_pkg::*;
    import vlsu_ctrl_pkg::*;

    localparam int NUM_OPS        = 32;
    localparam int TIMEOUT_CYCLES = 40 * NUM_OPS;

    logic                  clk;
    logic                  reset_n;
    logic                  start_i;
    logic [31:0]           instruction_i;
    logic [31:0]           base_address_i;
    logic [31:0]           stride_i;
    elem_idx_t             vl_i;
    logic [`VLSU_VLEN-1:0] write_data_i;
    logic [31:0]           mem_read_data;
    logic                  busy;
    logic                  done;
    logic [31:0]           mem_address;
    logic                  mem_read_enable;
    logic [3:0]            mem_write_enable;
    logic [31:0]           mem_write_data;
    logic [`VLSU_VLEN-1:0] read_data;

    logic [7:0]            mem [0:63];
    logic [7:0]            exp_mem [0:63];
    int                    seed = 32'h7118e75c;
    int                    cycle = 0;
    logic                  pending = 1'b0;
    vop_e                  exp_op;
    logic [`VLSU_VLEN-1:0] exp_image;
    int                    exp_done_cycle;
    int                    read_count = 0;
    int                    exp_reads;

    vlsu_top vlsu_top_inst (
        .clk(clk), .reset_n(reset_n), .start_i(start_i), .instruction_i(instruction_i),
        .base_address_i(base_address_i), .stride_i(stride_i), .vl_i(vl_i),
        .write_data_i(write_data_i), .mem_read_data_i(mem_read_data),
        .busy_o(busy), .done_o(done), .mem_address_o(mem_address),
        .mem_read_enable_o(mem_read_enable), .mem_write_enable_o(mem_write_enable),
        .mem_write_data_o(mem_write_data), .read_data_o(read_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Memory model and cycle counter
    ////////////////////////////////////////

    always @(posedge clk) begin
        mem_read_data <= #2 {mem[{mem_address[5:2], 2'd3}], mem[{mem_address[5:2], 2'd2}],
                             mem[{mem_address[5:2], 2'd1}], mem[{mem_address[5:2], 2'd0}]};
        for (int b = 0; b < 4; b++) begin
            if (mem_write_enable[b])
                mem[{mem_address[5:2], 2'(b)}] <= mem_write_data[8*b +: 8];
        end
        // Read cycles of the running operation
        if (reset_n && mem_read_enable)
            read_count = read_count + 1;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
            fail_now("Timeout: the tests did not finish within the cycle limit");
    end

    ////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_reg(input logic [`VLSU_VLEN-1:0] actual,
                             input logic [`VLSU_VLEN-1:0] expected, input string what);
        if (actual !== expected)
            fail_now($sformatf("ERROR @%0t: %s is %h, expected %h",
                               $time, what, actual, expected));
    endtask

    task automatic check_mem_byte(input int addr, input logic [7:0] actual,
                                  input logic [7:0] expected);
        if (actual !== expected)
            fail_now($sformatf("ERROR @%0t: memory byte %0d is %h, expected %h",
                               $time, addr, actual, expected));
    endtask

    task automatic check_state(input string what, input logic actual, input logic expected);
        if (actual !== expected)
            fail_now($sformatf("ERROR @%0t: %s is %b, expected %b",
                               $time, what, actual, expected));
    endtask

    task automatic check_count(input string what, input int actual, input int expected);
        if (actual != expected)
            fail_now($sformatf("ERROR @%0t: %s is %0d, expected %0d",
                               $time, what, actual, expected));
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Memory byte that register byte j maps to
    function automatic logic [5:0] lane_address(input vew_e w, input addr_mode_e mode,
                                                input logic [31:0] base,
                                                input logic [31:0] stride, input int j);
        int eb;
        eb = 1 << w;
        if (mode == UNIT_STRIDED)
            return 6'(base + j);
        return 6'(base + (j / eb) * stride + (j % eb));
    endfunction

    function automatic logic [`VLSU_VLEN-1:0] expected_image(input vew_e w,
            input addr_mode_e mode, input logic [31:0] base, input logic [31:0] stride,
            input elem_idx_t vl);
        logic [`VLSU_VLEN-1:0] img;
        img = '0;
        for (int j = 0; j < `VLSU_VLENB; j++) begin
            if ((j >> w) < vl)
                img[8*j +: 8] = exp_mem[lane_address(w, mode, base, stride, j)];
        end
        return img;
    endfunction

    task automatic apply_expected_store(input vew_e w, input addr_mode_e mode,
            input logic [31:0] base, input logic [31:0] stride, input elem_idx_t vl,
            input logic [`VLSU_VLEN-1:0] data);
        for (int j = 0; j < `VLSU_VLENB; j++) begin
            if ((j >> w) < vl)
                exp_mem[lane_address(w, mode, base, stride, j)] = data[8*j +: 8];
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] make_instr(input vop_e op, input vew_e w,
                                               input addr_mode_e mode);
        logic [31:0] instr;
        instr = '0;
        instr[`VLSU_OPC_MSB:`VLSU_OPC_LSB] = (op == VOP_STORE) ? `VLSU_OPC_STORE
                                                               : `VLSU_OPC_LOAD;
        case (w)
            EW8:     instr[`VLSU_WIDTH_MSB:`VLSU_WIDTH_LSB] = 3'b000;
            EW16:    instr[`VLSU_WIDTH_MSB:`VLSU_WIDTH_LSB] = 3'b101;
            default: instr[`VLSU_WIDTH_MSB:`VLSU_WIDTH_LSB] = 3'b110;
        endcase
        instr[`VLSU_MOP_MSB:`VLSU_MOP_LSB] = mode;
        return instr;
    endfunction

    function automatic int random_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic run_op(input vop_e op, input vew_e w, input addr_mode_e mode,
                          input logic poke_busy);
        int          eb;
        int          n;
        logic [31:0] base;
        logic [31:0] stride;
        elem_idx_t   vl;
        logic [63:0] data;
        eb     = 1 << w;
        base   = (mode == UNIT_STRIDED) ? 4 * random_below(16) : eb * random_below(64 / eb);
        stride = eb * (1 + random_below(6));
        vl     = elem_idx_t'(random_below(10));
        data   = {$random(seed), $random(seed)};
        n      = (mode == UNIT_STRIDED) ? 2 : ((vl > (8 >> w)) ? (8 >> w) : vl);
        if (op == VOP_LOAD)
            exp_image = expected_image(w, mode, base, stride, vl);
        else
            apply_expected_store(w, mode, base, stride, vl, data);
        exp_op    = op;
        exp_reads = (op == VOP_LOAD) ? n : 0;
        @(posedge clk);
        #2;
        instruction_i  = make_instr(op, w, mode);
        base_address_i = base;
        stride_i       = stride;
        vl_i           = vl;
        write_data_i   = data;
        start_i        = 1'b1;
        exp_done_cycle = cycle + 3 + n;
        read_count     = 0;
        pending        = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        if (poke_busy) begin
            // Second start lands while the first access is running
            @(posedge clk);
            #2;
            instruction_i = make_instr(VOP_STORE, EW8, UNIT_STRIDED);
            start_i       = 1'b1;
            @(posedge clk);
            #2;
            start_i = 1'b0;
        end
        wait (pending == 1'b0);
    endtask

    task automatic send_indexed(input addr_mode_e mode);
        @(posedge clk);
        #2;
        instruction_i = make_instr(VOP_LOAD, EW32, mode);
        start_i       = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_state("busy_o after indexed start", busy, 1'b0);
        end
    endtask

    ////////////////////////////////////////
    // Checker on done
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (reset_n && done) begin
            if (!pending)
                fail_now("done_o was raised although no operation had been started");
            if (cycle != exp_done_cycle)
                fail_now($sformatf("ERROR @%0t: done_o in cycle %0d, expected cycle %0d",
                                   $time, cycle, exp_done_cycle));
            check_count("cycles with mem_read_enable_o", read_count, exp_reads);
            if (exp_op == VOP_LOAD)
                check_reg(read_data, exp_image, "read_data_o");
            for (int a = 0; a < 64; a++)
                check_mem_byte(a, mem[a], exp_mem[a]);
            pending = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        reset_n        = 1'b0;
        start_i        = 1'b0;
        instruction_i  = '0;
        base_address_i = '0;
        stride_i       = '0;
        vl_i           = '0;
        write_data_i   = '0;
        mem_read_data  = '0;
        for (int a = 0; a < 64; a++) begin
            mem[a]     = 8'(a * 53 + 8'h17);
            exp_mem[a] = 8'(a * 53 + 8'h17);
        end
        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b1;

        @(negedge clk);
        check_state("busy_o after reset", busy, 1'b0);
        check_state("done_o after reset", done, 1'b0);
        check_state("mem_read_enable_o after reset", mem_read_enable, 1'b0);
        check_state("mem_write_enable_o after reset", |mem_write_enable, 1'b0);
        check_reg(read_data, '0, "read_data_o after reset");

        for (int w = 0; w < 3; w++)
            repeat (3) run_op(VOP_LOAD, vew_e'(w), UNIT_STRIDED, 1'b0);
        repeat (8) run_op(VOP_LOAD, vew_e'(random_below(3)), STRIDED, 1'b0);
        for (int w = 0; w < 3; w++)
            repeat (2) run_op(VOP_STORE, vew_e'(w), UNIT_STRIDED, 1'b0);
        repeat (6) run_op(VOP_STORE, vew_e'(random_below(3)), STRIDED, 1'b0);

        // Starts that must be dropped
        send_indexed(INDEXED_UNORDERED);
        send_indexed(INDEXED_ORDERED);
        run_op(VOP_LOAD, EW32, UNIT_STRIDED, 1'b1);

        repeat (6) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/vlsu_isa_pkg.sv
common/vlsu_ctrl_pkg.sv
vlsu/vlsu_decode.sv
vlsu/vlsu_execute.sv
vlsu/vlsu_result.sv
vlsu/vlsu_top.sv
tests/tb_vlsu.sv

//--- vlsu/vlsu_decode.sv
`timescale 1ns/1ps
`include "vlsu_config.svh"

module vlsu_decode (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start_i,
    input  logic [31:0]              instruction_i,
    input  logic [31:0]              base_address_i,
    input  logic [31:0]              stride_i,
    input  vlsu_ctrl_pkg::elem_idx_t vl_i,
    input  logic                     busy_i,
    output logic                     go_o,
    output vlsu_isa_pkg::vew_e       width_o,
    output vlsu_isa_pkg::addr_mode_e addr_mode_o,
    output vlsu_isa_pkg::vop_e       op_o,
    output logic [31:0]              base_address_o,
    output logic [31:0]              stride_o,
    output vlsu_ctrl_pkg::elem_idx_t vl_o,
    output vlsu_ctrl_pkg::elem_idx_t access_count_o
);
    import vlsu_isa_pkg::*;
    import vlsu_ctrl_pkg::*;

    logic       accept;
    logic       legal;
    logic [6:0] opcode;
    vew_e       width;
    addr_mode_e addr_mode;
    elem_idx_t  elems_per_reg;
    elem_idx_t  vl_clamped;

    ////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////

    assign accept    = start_i && !busy_i;
    assign opcode    = instruction_i[`VLSU_OPC_MSB:`VLSU_OPC_LSB];
    assign addr_mode = addr_mode_e'(instruction_i[`VLSU_MOP_MSB:`VLSU_MOP_LSB]);

    // 64-bit and reserved widths fall back to 32
    always_comb begin
        case (instruction_i[`VLSU_WIDTH_MSB:`VLSU_WIDTH_LSB])
            3'b000:  width = EW8;
            3'b101:  width = EW16;
            default: width = EW32;
        endcase
    end

    // Only unit-strided and strided moves are served
    assign legal = ((opcode == `VLSU_OPC_LOAD) || (opcode == `VLSU_OPC_STORE))
                && (addr_mode inside {UNIT_STRIDED, STRIDED});

    assign elems_per_reg = elem_idx_t'(`VLSU_VLENB >> width);
    assign vl_clamped    = (vl_i > elems_per_reg) ? elems_per_reg : vl_i;

    ////////////////////////////////////////
    // Latches
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            go_o           <= 1'b0;
            width_o        <= EW8;
            addr_mode_o    <= UNIT_STRIDED;
            op_o           <= VOP_LOAD;
            vl_o           <= '0;
            access_count_o <= '0;
        end else begin
            go_o <= accept && legal;
            if (accept && legal) begin
                width_o     <= width;
                addr_mode_o <= addr_mode;
                op_o        <= (opcode == `VLSU_OPC_STORE) ? VOP_STORE : VOP_LOAD;
                vl_o        <= vl_clamped;
                // Unit stride always sweeps the whole register
                access_count_o <= (addr_mode == UNIT_STRIDED)
                                ? elem_idx_t'(`VLSU_VLENB / (`VLSU_WORD_W / 8))
                                : vl_clamped;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && legal) begin
            base_address_o <= base_address_i;
            stride_o       <= stride_i;
        end
    end

endmodule

//--- vlsu/vlsu_execute.sv
`timescale 1ns/1ps
`include "vlsu_config.svh"

module vlsu_execute (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     go_i,
    input  vlsu_isa_pkg::vew_e       width_i,
    input  vlsu_isa_pkg::addr_mode_e addr_mode_i,
    input  vlsu_isa_pkg::vop_e       op_i,
    input  logic [31:0]              base_address_i,
    input  logic [31:0]              stride_i,
    input  vlsu_ctrl_pkg::elem_idx_t vl_i,
    input  vlsu_ctrl_pkg::elem_idx_t access_count_i,
    input  logic [`VLSU_VLEN-1:0]    write_data_i,
    output logic                     busy_o,
    output logic                     done_o,
    output logic [31:0]              mem_address_o,
    output logic                     mem_read_enable_o,
    output logic [3:0]               mem_write_enable_o,
    output logic [31:0]              mem_write_data_o,
    output logic                     rsp_valid_o,
    output vlsu_ctrl_pkg::elem_idx_t elem_idx_o,
    output logic [1:0]               byte_off_o,
    output vlsu_ctrl_pkg::elem_idx_t elems_o,
    output logic                     clear_o
);
    import vlsu_isa_pkg::*;
    import vlsu_ctrl_pkg::*;

    vlsu_state_e state;
    vlsu_state_e next_state;
    logic [31:0] offset;
    logic [31:0] address;
    logic [31:0] step;
    elem_idx_t   acc_cnt;
    elem_idx_t   elem_idx;
    elem_idx_t   elems;
    logic        last_access;

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    assign last_access = (acc_cnt == access_count_i - 1'b1);

    always_comb begin
        next_state = state;
        case (state)
            VLSU_IDLE: begin
                // Nothing to move goes straight to the drain cycle
                if (go_i)
                    next_state = (access_count_i == '0) ? VLSU_DRAIN : VLSU_ACCESS;
            end
            VLSU_ACCESS: begin
                if (last_access)
                    next_state = VLSU_DRAIN;
            end
            default: next_state = VLSU_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // Address and element counting
    ////////////////////////////////////////

    assign step    = (addr_mode_i == UNIT_STRIDED) ? 32'd4 : stride_i;
    assign address = base_address_i + offset;

    // Elements carried by one access
    assign elems = (addr_mode_i == UNIT_STRIDED) ? elem_idx_t'(3'd4 >> width_i)
                                                 : elem_idx_t'(1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= VLSU_IDLE;
            offset   <= '0;
            acc_cnt  <= '0;
            elem_idx <= '0;
            done_o   <= 1'b0;
        end else begin
            state  <= next_state;
            done_o <= (state == VLSU_DRAIN);
            if (state == VLSU_ACCESS) begin
                offset   <= offset + step;
                acc_cnt  <= acc_cnt + 1'b1;
                elem_idx <= elem_idx + elems;
            end else begin
                offset   <= '0;
                acc_cnt  <= '0;
                elem_idx <= '0;
            end
        end
    end

    ////////////////////////////////////////
    // Store byte enables and data
    ////////////////////////////////////////

    always_comb begin
        elem_idx_t lane_elem;
        mem_write_enable_o = 4'b0000;
        if (state == VLSU_ACCESS && op_i == VOP_STORE) begin
            if (addr_mode_i == UNIT_STRIDED) begin
                for (int i = 0; i < 4; i++) begin
                    lane_elem = elem_idx + elem_idx_t'(i >> width_i);
                    mem_write_enable_o[i] = (lane_elem < vl_i);
                end
            end else begin
                // One element, lanes picked by the low address bits
                case (width_i)
                    EW8:     mem_write_enable_o = 4'b0001 << address[1:0];
                    EW16:    mem_write_enable_o = address[1] ? 4'b1100 : 4'b0011;
                    default: mem_write_enable_o = 4'b1111;
                endcase
            end
        end
    end

    always_comb begin
        if (addr_mode_i == UNIT_STRIDED) begin
            mem_write_data_o = write_data_i[32*acc_cnt +: 32];
        end else begin
            case (width_i)
                EW8:     mem_write_data_o = {4{write_data_i[8*elem_idx +: 8]}};
                EW16:    mem_write_data_o = {2{write_data_i[16*elem_idx +: 16]}};
                default: mem_write_data_o = write_data_i[32*elem_idx +: 32];
            endcase
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    assign busy_o            = go_i || (state != VLSU_IDLE);
    assign mem_address_o     = address;
    assign mem_read_enable_o = (state == VLSU_ACCESS) && (op_i == VOP_LOAD);
    assign rsp_valid_o       = mem_read_enable_o;
    assign elem_idx_o        = elem_idx;
    assign byte_off_o        = address[1:0];
    assign elems_o           = elems;
    assign clear_o           = go_i;

endmodule

//--- vlsu/vlsu_result.sv
`timescale 1ns/1ps
`include "vlsu_config.svh"

module vlsu_result (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     clear_i,
    input  logic                     rsp_valid_i,
    input  vlsu_ctrl_pkg::elem_idx_t elem_idx_i,
    input  logic [1:0]               byte_off_i,
    input  vlsu_ctrl_pkg::elem_idx_t elems_i,
    input  vlsu_isa_pkg::vew_e       width_i,
    input  vlsu_ctrl_pkg::elem_idx_t vl_i,
    input  logic [31:0]              mem_read_data_i,
    output logic [`VLSU_VLEN-1:0]    read_data_o
);
    import vlsu_isa_pkg::*;
    import vlsu_ctrl_pkg::*;

    logic                  valid_q;
    elem_idx_t             idx_q;
    elem_idx_t             elems_q;
    logic [1:0]            off_q;
    logic [1:0]            lane_off;
    logic [31:0]           aligned;
    logic [`VLSU_VLEN-1:0] image_next;

    ////////////////////////////////////////
    // Stage barrier
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            valid_q <= 1'b0;
        else
            valid_q <= rsp_valid_i;
    end

    always_ff @(posedge clk) begin
        idx_q   <= elem_idx_i;
        off_q   <= byte_off_i;
        elems_q <= elems_i;
    end

    ////////////////////////////////////////
    // Lane extraction and image update
    ////////////////////////////////////////

    // Offset rounded down to the element size
    always_comb begin
        case (width_i)
            EW8:     lane_off = off_q;
            EW16:    lane_off = {off_q[1], 1'b0};
            default: lane_off = 2'b00;
        endcase
    end

    assign aligned = mem_read_data_i >> {lane_off, 3'b000};

    always_comb begin
        elem_idx_t elem;
        image_next = read_data_o;
        for (int e = 0; e < 4; e++) begin
            elem = idx_q + elem_idx_t'(e);
            // Tail elements stay zero
            if (e < elems_q && elem < vl_i) begin
                case (width_i)
                    EW8:     image_next[8*elem +: 8]   = aligned[8*e +: 8];
                    EW16:    image_next[16*elem +: 16] = aligned[16*e +: 16];
                    default: image_next[32*elem +: 32] = aligned;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            read_data_o <= '0;
        else if (clear_i)
            read_data_o <= '0;
        else if (valid_q)
            read_data_o <= image_next;
    end

endmodule

//--- vlsu/vlsu_top.sv
`timescale 1ns/1ps
`include "vlsu_config.svh"

module vlsu_top (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start_i,
    input  logic [31:0]              instruction_i,
    input  logic [31:0]              base_address_i,
    input  logic [31:0]              stride_i,
    input  vlsu_ctrl_pkg::elem_idx_t vl_i,
    input  logic [`VLSU_VLEN-1:0]    write_data_i,
    input  logic [31:0]              mem_read_data_i,
    output logic                     busy_o,
    output logic                     done_o,
    output logic [31:0]              mem_address_o,
    output logic                     mem_read_enable_o,
    output logic [3:0]               mem_write_enable_o,
    output logic [31:0]              mem_write_data_o,
    output logic [`VLSU_VLEN-1:0]    read_data_o
);
    import vlsu_isa_pkg::*;
    import vlsu_ctrl_pkg::*;

    // Decode to execute
    logic        go;
    vew_e        width;
    addr_mode_e  addr_mode;
    vop_e        op;
    logic [31:0] base_address;
    logic [31:0] stride;
    elem_idx_t   vl;
    elem_idx_t   access_count;

    // Execute to result
    logic        rsp_valid;
    elem_idx_t   elem_idx;
    logic [1:0]  byte_off;
    elem_idx_t   elems;
    logic        clear;

    vlsu_decode vlsu_decode_inst (
        .clk(clk), .reset_n(reset_n), .start_i(start_i), .instruction_i(instruction_i),
        .base_address_i(base_address_i), .stride_i(stride_i), .vl_i(vl_i), .busy_i(busy_o),
        .go_o(go), .width_o(width), .addr_mode_o(addr_mode), .op_o(op),
        .base_address_o(base_address), .stride_o(stride), .vl_o(vl),
        .access_count_o(access_count)
    );

    vlsu_execute vlsu_execute_inst (
        .clk(clk), .reset_n(reset_n), .go_i(go), .width_i(width), .addr_mode_i(addr_mode),
        .op_i(op), .base_address_i(base_address), .stride_i(stride), .vl_i(vl),
        .access_count_i(access_count), .write_data_i(write_data_i),
        .busy_o(busy_o), .done_o(done_o), .mem_address_o(mem_address_o),
        .mem_read_enable_o(mem_read_enable_o), .mem_write_enable_o(mem_write_enable_o),
        .mem_write_data_o(mem_write_data_o), .rsp_valid_o(rsp_valid), .elem_idx_o(elem_idx),
        .byte_off_o(byte_off), .elems_o(elems), .clear_o(clear)
    );

    vlsu_result vlsu_result_inst (
        .clk(clk), .reset_n(reset_n), .clear_i(clear), .rsp_valid_i(rsp_valid),
        .elem_idx_i(elem_idx), .byte_off_i(byte_off), .elems_i(elems), .width_i(width),
        .vl_i(vl), .mem_read_data_i(mem_read_data_i), .read_data_o(read_data_o)
    );

endmodule
